// ==== verilog.f ====
+incdir+include
rtl/atom_decode_pkg.sv
rtl/ctrl_decoder.sv
rtl/imm_extractor.sv
rtl/decode_stage.sv
verification/decode_checker.sv
verification/tb_decode_stage.sv

// ==== Makefile ====
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/tb_decode_stage.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the RV32I decode stage. Sends LCG-generated streams
// of instructions in four tests; decode_checker models the decoder
// and counts mismatches, this top reports the results.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "atom_decode_consts.svh"

module tb_decode_stage
    import atom_decode_pkg::*;
();

    localparam int num_tests  = 4;
    localparam int num_instr  = 400;
    localparam int max_cycles = num_tests * num_instr * 2 + 800;

    logic        clk_i;
    logic        reset_i;
    logic        instr_valid_i;
    instr_u      instr_i;
    logic        dec_valid_o;
    dec_out_t    dec_o;
    int          error_count;
    int          check_count;
    int          cycles = 0;
    logic [31:0] seed;

    decode_stage decode_stage_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .dec_valid_o   (dec_valid_o),
        .dec_o         (dec_o)
    );

    decode_checker decode_checker_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .dec_valid_i   (dec_valid_o),
        .dec_i         (dec_o),
        .error_count_o (error_count),
        .check_count_o (check_count)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i)
    begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles)
        begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed ^ (seed >> 16);    // Fold high bits into the weak low ones
    endfunction

    //////////////////////////////////////////////////////////////////
    // Instruction templates
    //////////////////////////////////////////////////////////////////
    function automatic logic [31:0] build_instr(input int cls, input logic [31:0] r,
                                                input logic [7:0] s);
        logic [6:0] f7;
        logic [2:0] f3;
        logic [6:0] opc;
        f7  = r[31:25];
        f3  = r[14:12];
        opc = `OPC_OP_IMM;             // Class 7 keeps it
        case (cls)
            0: opc = `OPC_LUI;
            1: opc = `OPC_AUIPC;
            2: opc = `OPC_JAL;
            3:
            begin
                opc = `OPC_JALR;
                f3  = 3'b000;
            end
            4:
            begin
                opc = `OPC_BRANCH;
                if (f3[2:1] == 2'b01)
                    f3[2] = 1'b1;
            end
            5:
            begin
                opc = `OPC_LOAD;
                if (f3 == 3'b011 || f3[2:1] == 2'b11)
                    f3 = f3 & 3'b101;
            end
            6:
            begin
                opc = `OPC_STORE;
                if (f3 > 3'b010)
                    f3 = {2'b00, f3[0]};
            end
            7:
            begin
                if (f3 == 3'b001 || f3 == 3'b101)   // Shifts by immediate
                    f7 = (f3[2] && s[0]) ? 7'b0100000 : 7'b0000000;
            end
            8:
            begin
                opc = `OPC_OP;
                f7  = ((f3 == 3'b000 || f3 == 3'b101) && s[0]) ? 7'b0100000 : 7'b0000000;
            end
            9:
            begin
                case (s[2:0])
                    3'd0: return 32'h0000_0073;    // ECALL
                    3'd1: return 32'h0010_0073;    // EBREAK
                    3'd2: return 32'h3020_0073;    // MRET
                    3'd3: return 32'h1050_0073;    // WFI
                    default: opc = `OPC_SYSTEM;    // CSR forms
                endcase
            end
            10:
            begin
                case (s[1:0])
                    2'd0:
                    begin
                        opc = `OPC_BRANCH;
                        f3  = {2'b01, f3[0]};
                    end
                    2'd1:
                    begin
                        opc = `OPC_JALR;
                        f3  = f3 | 3'b001;
                    end
                    2'd2:
                    begin
                        opc = `OPC_LOAD;
                        f3  = s[2] ? 3'b011 : {2'b11, f3[0]};
                    end
                    default:
                    begin
                        opc = `OPC_STORE;
                        f3  = {1'b1, f3[1:0]};
                    end
                endcase
            end
            11:
            begin
                opc = s[0] ? `OPC_OP : `OPC_OP_IMM;
                f7  = f7 | 7'b0000001;          // Neither 0 nor 0100000
                if (!s[0])
                    f3 = s[1] ? 3'b001 : 3'b101;
            end
            default: return r;                  // Fully random word
        endcase
        return {f7, r[24:15], f3, r[11:7], opc};
    endfunction

    function automatic logic [31:0] pick_instr(input int test);
        logic [31:0] sel;
        int          cls;
        sel = next_rand();
        case (test)
            0: cls = int'(sel[31:24]) % 9;       // Legal classes
            1: cls = 9 + int'(sel[31:24]) % 4;   // SYSTEM, bad fields, random
            default: cls = int'(sel[31:24]) % 13;
        endcase
        return build_instr(cls, next_rand(), sel[23:16]);
    endfunction

    function automatic string test_name(input int test);
        case (test)
            0: return "legal classes";
            1: return "illegal encodings";
            2: return "mixed stream";
            default: return "back-to-back";
        endcase
    endfunction

    task automatic run_test(input int test);
        int          sent;
        logic [31:0] r;
        sent = 0;
        while (sent < num_instr)
        begin
            @(posedge clk_i);
            r = next_rand();
            if (test == 3 || r[31:30] != 2'b00)
            begin
                instr_valid_i <= 1'b1;
                instr_i       <= pick_instr(test);
                sent++;
            end
            else
                instr_valid_i <= 1'b0;
        end
        @(posedge clk_i);
        instr_valid_i <= 1'b0;
        repeat (2) @(posedge clk_i);   // Last result reaches the checker
        @(negedge clk_i);              // Counts settled after the checker ran
    endtask

    initial
    begin
        int errors_before;
        seed          = 32'd10580;
        reset_i       = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        repeat (16) @(posedge clk_i);
        reset_i <= 1'b0;

        for (int t = 0; t < num_tests; t++)
        begin
            errors_before = error_count;
            run_test(t);
            $display("Test %0d (%s): %0d instructions, %0d errors", t, test_name(t),
                     num_instr, error_count - errors_before);
        end

        if (check_count != num_tests * num_instr)
            $display("Only %0d of %0d decoded instructions were compared", check_count,
                     num_tests * num_instr);
        $display("Summary: %0d tests, %0d checks, %0d errors", num_tests, check_count,
                 error_count);
        if (error_count == 0 && check_count == num_tests * num_instr)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/decode_checker.sv ====
//////////////////////////////////////////////////////////////////////
// Reference model and scoreboard for the decode stage. Queues the
// expected bundle of each valid instruction, compares it one cycle
// later and checks that dec_o holds across idle cycles.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "atom_decode_consts.svh"

module decode_checker
    import atom_decode_pkg::*;
(
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     instr_valid_i,
    input  instr_u   instr_i,
    input  logic     dec_valid_i,
    input  dec_out_t dec_i,
    output int       error_count_o,
    output int       check_count_o
);

    localparam logic yes = 1'b1;
    localparam logic no  = 1'b0;

    dec_out_t expect_q[$];
    dec_out_t want;
    dec_out_t last_want;
    logic     have_last  = 1'b0;
    logic     reset_seen = 1'b0;
    int       errors     = 0;
    int       checks     = 0;

    assign error_count_o = errors;
    assign check_count_o = checks;

    task automatic note_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic check_field(input string name, input string when,
                               input logic [31:0] want_v, input logic [31:0] got_v);
        if (got_v !== want_v)
        begin
            $display("CHECK FAILED %s (%s): expected 0x%h, actual 0x%h", name, when,
                     want_v, got_v);
            errors++;
        end
    endtask

    task automatic compare_bundle(input dec_out_t w, input string when);
        check_field("dec_o.ctrl.jump_en", when, w.ctrl.jump_en, dec_i.ctrl.jump_en);
        check_field("dec_o.ctrl.cmp_type", when, w.ctrl.cmp_type, dec_i.ctrl.cmp_type);
        check_field("dec_o.ctrl.rf_we", when, w.ctrl.rf_we, dec_i.ctrl.rf_we);
        check_field("dec_o.ctrl.rf_din_sel", when, w.ctrl.rf_din_sel, dec_i.ctrl.rf_din_sel);
        check_field("dec_o.ctrl.a_op_sel", when, w.ctrl.a_op_sel, dec_i.ctrl.a_op_sel);
        check_field("dec_o.ctrl.b_op_sel", when, w.ctrl.b_op_sel, dec_i.ctrl.b_op_sel);
        check_field("dec_o.ctrl.cmp_b_op_sel", when, w.ctrl.cmp_b_op_sel,
                    dec_i.ctrl.cmp_b_op_sel);
        check_field("dec_o.ctrl.alu_op", when, w.ctrl.alu_op, dec_i.ctrl.alu_op);
        check_field("dec_o.ctrl.mem_ls", when, w.ctrl.mem_ls, dec_i.ctrl.mem_ls);
        check_field("dec_o.ctrl.mem_we", when, w.ctrl.mem_we, dec_i.ctrl.mem_we);
        check_field("dec_o.ctrl.illegal", when, w.ctrl.illegal, dec_i.ctrl.illegal);
        check_field("dec_o.imm", when, w.imm, dec_i.imm);
        check_field("dec_o.rd_sel", when, w.rd_sel, dec_i.rd_sel);
        check_field("dec_o.rs1_sel", when, w.rs1_sel, dec_i.rs1_sel);
        check_field("dec_o.rs2_sel", when, w.rs2_sel, dec_i.rs2_sel);
        check_field("dec_o.mem_width", when, w.mem_width, dec_i.mem_width);
    endtask

    function automatic exec_ctrl_t ctrl_of(input logic jump, input logic [2:0] cmp,
                                           input logic we, input logic [2:0] src,
                                           input logic a_pc, input logic b_imm,
                                           input logic cmp_imm, input logic [2:0] alu,
                                           input logic ls, input logic st);
        exec_ctrl_t c;
        c.jump_en      = jump;
        c.cmp_type     = cmp;
        c.rf_we        = we;
        c.rf_din_sel   = src;
        c.a_op_sel     = a_pc;
        c.b_op_sel     = b_imm;
        c.cmp_b_op_sel = cmp_imm;
        c.alu_op       = alu;
        c.mem_ls       = ls;
        c.mem_we       = st;
        c.illegal      = 1'b0;
        return c;
    endfunction

    //////////////////////////////////////////////////////////////////
    // Reference decoder
    //////////////////////////////////////////////////////////////////
    function automatic dec_out_t model(input logic [31:0] w);
        dec_out_t   d;
        exec_ctrl_t c;
        logic [2:0] fmt;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [2:0] cmp;
        logic [2:0] alu;
        logic       op;
        logic       alt;
        logic       bad;
        logic       f7_good;
        f3  = w[14:12];
        f7  = w[31:25];
        op  = (w[6:0] == `OPC_OP);
        alt = (f7 == 7'b0100000);
        c   = '0;                      // UN, ADD, every select 0
        fmt = `IMM_U;
        bad = 1'b0;
        case (w[6:0])
            `OPC_LUI:
                c = ctrl_of(no, `CMP_UN, yes, `RF_SRC_IMM, no, no, no, `ALU_ADD, no, no);
            `OPC_AUIPC:
                c = ctrl_of(no, `CMP_UN, yes, `RF_SRC_ALU, yes, yes, no, `ALU_ADD, no, no);
            `OPC_JAL:
            begin
                c   = ctrl_of(yes, `CMP_UN, yes, `RF_SRC_PC4, yes, yes, no, `ALU_ADD, no, no);
                fmt = `IMM_J;
            end
            `OPC_JALR:
            begin
                bad = (f3 != 3'b000);
                if (!bad)
                begin
                    c   = ctrl_of(yes, `CMP_UN, yes, `RF_SRC_PC4, no, yes, no, `ALU_ADD, no, no);
                    fmt = `IMM_I;
                end
            end
            `OPC_BRANCH:
            begin
                case (f3)
                    3'b000: cmp = `CMP_EQ;
                    3'b001: cmp = `CMP_NQ;
                    3'b100: cmp = `CMP_LT;
                    3'b101: cmp = `CMP_GE;
                    3'b110: cmp = `CMP_LTU;
                    default: cmp = `CMP_GEU;
                endcase
                bad = (f3 == 3'b010 || f3 == 3'b011);
                if (!bad)
                begin
                    c   = ctrl_of(yes, cmp, no, `RF_SRC_IMM, yes, yes, no, `ALU_ADD, no, no);
                    fmt = `IMM_B;
                end
            end
            `OPC_LOAD:
            begin
                c   = ctrl_of(no, `CMP_UN, yes, `RF_SRC_MEM, no, yes, no, `ALU_ADD, yes, no);
                fmt = `IMM_I;
                bad = (f3 == 3'b011 || f3 >= 3'b110);
            end
            `OPC_STORE:
            begin
                c   = ctrl_of(no, `CMP_UN, no, `RF_SRC_IMM, no, yes, no, `ALU_ADD, yes, yes);
                fmt = `IMM_S;
                bad = (f3 >= 3'b011);
            end
            `OPC_OP_IMM, `OPC_OP:
            begin
                if (op)
                    f7_good = (f3 == 3'b000 || f3 == 3'b101) ? (f7 == 7'd0 || alt) : (f7 == 7'd0);
                else
                    f7_good = (f3 == 3'b001) ? (f7 == 7'd0) : (f3 != 3'b101 || f7 == 7'd0 || alt);
                case (f3)
                    3'b001: alu = `ALU_SLL;
                    3'b100: alu = `ALU_XOR;
                    3'b101: alu = alt ? `ALU_SRA : `ALU_SRL;
                    3'b110: alu = `ALU_OR;
                    3'b111: alu = `ALU_AND;
                    default: alu = (op && alt) ? `ALU_SUB : `ALU_ADD;
                endcase
                bad = !f7_good;
                if (f7_good && f3[2:1] == 2'b01)    // SLT family
                    c = ctrl_of(no, f3[0] ? `CMP_LTU : `CMP_LT, yes, `RF_SRC_CMP, no, !op, !op,
                                `ALU_ADD, no, no);
                else if (f7_good)
                    c = ctrl_of(no, `CMP_UN, yes, `RF_SRC_ALU, no, !op, no, alu, no, no);
                if (f7_good && !op)
                    fmt = `IMM_I;
            end
            default: bad = 1'b1;       // SYSTEM included
        endcase

        d              = '0;
        d.ctrl         = c;
        d.ctrl.illegal = bad;
        case (fmt)
            `IMM_I: d.imm = {{20{w[31]}}, w[31:20]};
            `IMM_S: d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            `IMM_B: d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            `IMM_U: d.imm = {w[31:12], 12'h000};
            default: d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        endcase
        d.rd_sel    = w[11:7];
        d.rs1_sel   = w[19:15];
        d.rs2_sel   = w[24:20];
        d.mem_width = f3;
        return d;
    endfunction

    always @(posedge clk_i)
    begin
        if (reset_i)
        begin
            if (reset_seen)
            begin
                if (dec_valid_i !== 1'b0)
                    note_error("dec_valid_o is not low during reset");
                // Side-effect controls are cleared by reset
                check_field("dec_o.ctrl.jump_en", "reset", 32'd0, dec_i.ctrl.jump_en);
                check_field("dec_o.ctrl.rf_we", "reset", 32'd0, dec_i.ctrl.rf_we);
                check_field("dec_o.ctrl.mem_ls", "reset", 32'd0, dec_i.ctrl.mem_ls);
                check_field("dec_o.ctrl.mem_we", "reset", 32'd0, dec_i.ctrl.mem_we);
            end
            reset_seen = 1'b1;
            have_last  = 1'b0;
            expect_q.delete();
        end
        else
        begin
            if (expect_q.size() != 0)
            begin
                want = expect_q.pop_front();
                if (dec_valid_i !== 1'b1)
                    note_error("dec_valid_o missing one cycle after a valid instruction");
                else
                begin
                    compare_bundle(want, "decode");
                    checks++;
                end
                last_want = want;
                have_last = 1'b1;
            end
            else if (dec_valid_i !== 1'b0)
                note_error("dec_valid_o high without a valid instruction a cycle earlier");
            else if (have_last)
                compare_bundle(last_want, "hold");   // Idle cycle keeps the old bundle

            if (instr_valid_i)
                expect_q.push_back(model(instr_i));
        end
    end

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
//////////////////////////////////////////////////////////////////////
// RV32I decode stage. Control decode and immediate build run side by
// side; the result is registered, one cycle after instr_valid_i.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "atom_decode_consts.svh"

module decode_stage
    import atom_decode_pkg::*;
(
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     instr_valid_i,
    input  instr_u   instr_i,
    output logic     dec_valid_o,
    output dec_out_t dec_o
);

    ctrl_t            ctrl;
    imm_set_t         imm_set;
    logic [`XLEN-1:0] imm_sel;
    dec_out_t         dec_d;
    dec_out_t         dec_q;
    logic             dec_valid_q;

    ctrl_decoder ctrl_decoder_i (
        .instr_i (instr_i),
        .ctrl_o  (ctrl)
    );

    imm_extractor imm_extractor_i (
        .instr_i (instr_i),
        .imm_o   (imm_set)
    );

    always_comb
    begin
        case (ctrl.imm_fmt)
            `IMM_I: imm_sel = imm_set.imm_i;
            `IMM_S: imm_sel = imm_set.imm_s;
            `IMM_B: imm_sel = imm_set.imm_b;
            `IMM_U: imm_sel = imm_set.imm_u;
            `IMM_J: imm_sel = imm_set.imm_j;
            default: imm_sel = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////
    // Output bundle
    //////////////////////////////////////////////////////////////////
    always_comb
    begin
        dec_d.ctrl.jump_en      = ctrl.jump_en;
        dec_d.ctrl.cmp_type     = ctrl.cmp_type;
        dec_d.ctrl.rf_we        = ctrl.rf_we;
        dec_d.ctrl.rf_din_sel   = ctrl.rf_din_sel;
        dec_d.ctrl.a_op_sel     = ctrl.a_op_sel;
        dec_d.ctrl.b_op_sel     = ctrl.b_op_sel;
        dec_d.ctrl.cmp_b_op_sel = ctrl.cmp_b_op_sel;
        dec_d.ctrl.alu_op       = ctrl.alu_op;
        dec_d.ctrl.mem_ls       = ctrl.mem_ls;
        dec_d.ctrl.mem_we       = ctrl.mem_we;
        dec_d.ctrl.illegal      = ctrl.illegal;
        dec_d.imm               = imm_sel;
        dec_d.rd_sel            = instr_i.r.rd;
        dec_d.rs1_sel           = instr_i.r.rs1;
        dec_d.rs2_sel           = instr_i.r.rs2;
        dec_d.mem_width         = instr_i.r.func3;
    end

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            dec_valid_q        <= 1'b0;
            dec_q.ctrl.jump_en <= 1'b0;    // Side effects off
            dec_q.ctrl.rf_we   <= 1'b0;
            dec_q.ctrl.mem_ls  <= 1'b0;
            dec_q.ctrl.mem_we  <= 1'b0;
        end
        else
        begin
            dec_valid_q <= instr_valid_i;
            if (instr_valid_i)
                dec_q <= dec_d;             // Holds on idle cycles
        end
    end

    assign dec_valid_o = dec_valid_q;
    assign dec_o       = dec_q;

    //////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////
    a_no_valid_after_reset: assert property (
        @(posedge clk_i) reset_i |=> !dec_valid_o
    ) else $error("dec_valid_o high after reset");

    a_no_load_store_clash: assert property (
        @(posedge clk_i) disable iff (reset_i)
        dec_valid_o |-> !(dec_o.ctrl.rf_we && dec_o.ctrl.mem_we)
    ) else $error("rf_we and mem_we both set");

endmodule

`default_nettype wire

// ==== rtl/imm_extractor.sv ====
//////////////////////////////////////////////////////////////////////
// Builds all five RV32I immediates of one instruction in parallel.
// Combinational; the caller picks one by format.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "atom_decode_consts.svh"

module imm_extractor
    import atom_decode_pkg::*;
(
    input  instr_u   instr_i,
    output imm_set_t imm_o
);

    logic sign;

    assign sign = instr_i.r.func7[6];   // Always instr[31]

    assign imm_o.imm_i = {{(`XLEN-12){sign}}, instr_i.i.imm12};
    assign imm_o.imm_s = {{(`XLEN-12){sign}}, instr_i.r.func7, instr_i.r.rd};

    // imm[12|10:5] in func7, imm[4:1|11] in rd
    assign imm_o.imm_b = {{(`XLEN-12){sign}}, instr_i.r.rd[0], instr_i.r.func7[5:0],
                          instr_i.r.rd[4:1], 1'b0};

    assign imm_o.imm_u = {instr_i.r.func7, instr_i.r.rs2, instr_i.r.rs1,
                          instr_i.r.func3, 12'b0};

    // imm[20|10:1|11|19:12]
    assign imm_o.imm_j = {{(`XLEN-20){sign}}, instr_i.r.rs1, instr_i.r.func3,
                          instr_i.r.rs2[0], instr_i.r.func7[5:0], instr_i.r.rs2[4:1], 1'b0};

endmodule

`default_nettype wire

// ==== rtl/ctrl_decoder.sv ====
//////////////////////////////////////////////////////////////////////
// RV32I control decoder. Purely combinational; maps opcode, func3
// and func7 to the datapath controls, the immediate format and the
// illegal flag.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "atom_decode_consts.svh"

module ctrl_decoder
    import atom_decode_pkg::*;
(
    input  instr_u instr_i,
    output ctrl_t  ctrl_o
);

    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       is_op;
    logic       f7_zero;
    logic       f7_alt;
    logic       f7_ok;
    logic [2:0] alu_fn;

    assign opc     = instr_i.r.opcode;
    assign f3      = instr_i.r.func3;
    assign f7      = instr_i.r.func7;
    assign is_op   = (opc == `OPC_OP);
    assign f7_zero = (f7 == 7'b0000000);
    assign f7_alt  = (f7 == 7'b0100000);

    // func7 check and ALU function shared by OP-IMM and OP
    always_comb
    begin
        case (f3)
            3'b000: f7_ok = !is_op || f7_zero || f7_alt;
            3'b001: f7_ok = f7_zero;             // SLL(I)
            3'b101: f7_ok = f7_zero || f7_alt;   // SRL(I) / SRA(I)
            default: f7_ok = !is_op || f7_zero;
        endcase

        case (f3)
            3'b000: alu_fn = (is_op && f7_alt) ? `ALU_SUB : `ALU_ADD;
            3'b001: alu_fn = `ALU_SLL;
            3'b100: alu_fn = `ALU_XOR;
            3'b101: alu_fn = f7_alt ? `ALU_SRA : `ALU_SRL;
            3'b110: alu_fn = `ALU_OR;
            3'b111: alu_fn = `ALU_AND;
            default: alu_fn = `ALU_ADD;
        endcase
    end

    always_comb
    begin
        ctrl_o          = '0;
        ctrl_o.cmp_type = `CMP_UN;
        ctrl_o.alu_op   = `ALU_ADD;
        ctrl_o.imm_fmt  = `IMM_U;

        case (opc)
            `OPC_LUI:
            begin
                ctrl_o.rf_we      = 1'b1;
                ctrl_o.rf_din_sel = `RF_SRC_IMM;
            end

            `OPC_AUIPC:
            begin
                ctrl_o.rf_we      = 1'b1;
                ctrl_o.rf_din_sel = `RF_SRC_ALU;
                ctrl_o.a_op_sel   = 1'b1;
                ctrl_o.b_op_sel   = 1'b1;
            end

            `OPC_JAL:
            begin
                ctrl_o.jump_en    = 1'b1;
                ctrl_o.rf_we      = 1'b1;
                ctrl_o.rf_din_sel = `RF_SRC_PC4;
                ctrl_o.a_op_sel   = 1'b1;
                ctrl_o.b_op_sel   = 1'b1;
                ctrl_o.imm_fmt    = `IMM_J;
            end

            `OPC_JALR:
            begin
                if (f3 == 3'b000)
                begin
                    ctrl_o.jump_en    = 1'b1;
                    ctrl_o.rf_we      = 1'b1;
                    ctrl_o.rf_din_sel = `RF_SRC_PC4;
                    ctrl_o.b_op_sel   = 1'b1;  // rs1 + imm
                    ctrl_o.imm_fmt    = `IMM_I;
                end
                else
                    ctrl_o.illegal = 1'b1;
            end

            `OPC_BRANCH:
            begin
                if (f3[2:1] == 2'b01)
                    ctrl_o.illegal = 1'b1;
                else
                begin
                    ctrl_o.jump_en  = 1'b1;
                    ctrl_o.a_op_sel = 1'b1;    // Target is PC + imm
                    ctrl_o.b_op_sel = 1'b1;
                    ctrl_o.imm_fmt  = `IMM_B;
                    case (f3)
                        3'b000: ctrl_o.cmp_type = `CMP_EQ;
                        3'b001: ctrl_o.cmp_type = `CMP_NQ;
                        3'b100: ctrl_o.cmp_type = `CMP_LT;
                        3'b101: ctrl_o.cmp_type = `CMP_GE;
                        3'b110: ctrl_o.cmp_type = `CMP_LTU;
                        default: ctrl_o.cmp_type = `CMP_GEU;
                    endcase
                end
            end

            // Bad width still flags illegal but keeps the load controls
            `OPC_LOAD:
            begin
                ctrl_o.rf_we      = 1'b1;
                ctrl_o.rf_din_sel = `RF_SRC_MEM;
                ctrl_o.b_op_sel   = 1'b1;
                ctrl_o.mem_ls     = 1'b1;
                ctrl_o.imm_fmt    = `IMM_I;
                ctrl_o.illegal    = (f3 == 3'b011) || (f3[2:1] == 2'b11);
            end

            `OPC_STORE:
            begin
                ctrl_o.b_op_sel = 1'b1;
                ctrl_o.mem_ls   = 1'b1;
                ctrl_o.mem_we   = 1'b1;
                ctrl_o.imm_fmt  = `IMM_S;
                ctrl_o.illegal  = (f3 > 3'b010);
            end

            `OPC_OP_IMM, `OPC_OP:
            begin
                if (!f7_ok)
                    ctrl_o.illegal = 1'b1;
                else
                begin
                    ctrl_o.rf_we    = 1'b1;
                    ctrl_o.b_op_sel = !is_op;
                    if (!is_op)
                        ctrl_o.imm_fmt = `IMM_I;

                    if (f3[2:1] == 2'b01)      // SLT(I)(U)
                    begin
                        ctrl_o.rf_din_sel   = `RF_SRC_CMP;
                        ctrl_o.cmp_type     = f3[0] ? `CMP_LTU : `CMP_LT;
                        ctrl_o.cmp_b_op_sel = !is_op;
                    end
                    else
                    begin
                        ctrl_o.rf_din_sel = `RF_SRC_ALU;
                        ctrl_o.alu_op     = alu_fn;
                    end
                end
            end

            `OPC_SYSTEM: ctrl_o.illegal = 1'b1;  // No traps or CSRs here

            default: ctrl_o.illegal = 1'b1;
        endcase
    end

    always_comb
    begin
        assert (!ctrl_o.mem_we || ctrl_o.mem_ls)
            else $error("mem_we set without mem_ls");
    end

endmodule

`default_nettype wire

// ==== rtl/atom_decode_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Types shared by the decode stage and its testbench: the instruction
// word with its R and I views, the control bundle, the immediate set
// and the registered output bundle.
//////////////////////////////////////////////////////////////////////
`default_nettype none

`include "atom_decode_consts.svh"

package atom_decode_pkg;

    typedef struct packed {
        logic [6:0]  func7;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  func3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  func3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    // Same word, read as R or I format
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef struct packed {
        logic        jump_en;
        logic [2:0]  cmp_type;
        logic        rf_we;
        logic [2:0]  rf_din_sel;
        logic        a_op_sel;     // 1: PC
        logic        b_op_sel;     // 1: immediate
        logic        cmp_b_op_sel; // 1: immediate
        logic [2:0]  alu_op;
        logic        mem_ls;
        logic        mem_we;
        logic [2:0]  imm_fmt;
        logic        illegal;
    } ctrl_t;

    // Controls as they leave the stage, format already applied
    typedef struct packed {
        logic        jump_en;
        logic [2:0]  cmp_type;
        logic        rf_we;
        logic [2:0]  rf_din_sel;
        logic        a_op_sel;
        logic        b_op_sel;
        logic        cmp_b_op_sel;
        logic [2:0]  alu_op;
        logic        mem_ls;
        logic        mem_we;
        logic        illegal;
    } exec_ctrl_t;

    typedef struct packed {
        logic [`XLEN-1:0] imm_i;
        logic [`XLEN-1:0] imm_s;
        logic [`XLEN-1:0] imm_b;
        logic [`XLEN-1:0] imm_u;
        logic [`XLEN-1:0] imm_j;
    } imm_set_t;

    typedef struct packed {
        exec_ctrl_t       ctrl;
        logic [`XLEN-1:0] imm;
        logic [4:0]       rd_sel;
        logic [4:0]       rs1_sel;
        logic [4:0]       rs2_sel;
        logic [2:0]       mem_width;
    } dec_out_t;

endpackage

`default_nettype wire

// ==== include/atom_decode_consts.svh ====
//////////////////////////////////////////////////////////////////////
// Constants of the RV32I decode stage: word width, major opcodes,
// immediate formats and datapath control codes. Include wherever
// these codes are compared or produced.
//////////////////////////////////////////////////////////////////////
`ifndef ATOM_DECODE_CONSTS_SVH
`define ATOM_DECODE_CONSTS_SVH

`define XLEN            32

// Major opcodes
`define OPC_LUI         7'b0110111
`define OPC_AUIPC       7'b0010111
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_BRANCH      7'b1100011
`define OPC_LOAD        7'b0000011
`define OPC_STORE       7'b0100011
`define OPC_OP_IMM      7'b0010011
`define OPC_OP          7'b0110011
`define OPC_SYSTEM      7'b1110011

// Immediate formats
`define IMM_I           3'd0
`define IMM_S           3'd1
`define IMM_B           3'd2
`define IMM_U           3'd3
`define IMM_J           3'd4

// ALU functions
`define ALU_ADD         3'd0
`define ALU_SUB         3'd1
`define ALU_XOR         3'd2
`define ALU_OR          3'd3
`define ALU_AND         3'd4
`define ALU_SLL         3'd5
`define ALU_SRL         3'd6
`define ALU_SRA         3'd7

// Comparisons where UN means unconditional
`define CMP_UN          3'd0
`define CMP_EQ          3'd1
`define CMP_NQ          3'd2
`define CMP_LT          3'd3
`define CMP_GE          3'd4
`define CMP_LTU         3'd5
`define CMP_GEU         3'd6

// Register file write-back sources
`define RF_SRC_IMM      3'd0
`define RF_SRC_PC4      3'd1
`define RF_SRC_ALU      3'd2
`define RF_SRC_CMP      3'd3
`define RF_SRC_MEM      3'd4

`endif
